// File: lcd_timing_pkg.sv
`default_nettype none

package lcd_timing_pkg;

	////////////////////
	// Tick timing
	////////////////////

	// Width of the divider count, enough for the default period
	typedef logic [19:0] tick_cnt_t;

	// Clocks per bus phase, about 10 ms at 100 MHz
	localparam tick_cnt_t TICK_CYCLES = 20'd1_000_000;

endpackage

`default_nettype wire

// File: lcd_cmd_pkg.sv
`default_nettype none

package lcd_cmd_pkg;

	////////////////////
	// Display geometry
	////////////////////

	localparam int LINE_CHARS = 16;
	localparam int WAKE_NIBBLES = 4;
	localparam int CONFIG_BYTES = 5;

	////////////////////
	// Data types
	////////////////////

	// 4-bit bus value
	typedef logic [3:0] nibble_t;

	// Character or command byte
	typedef logic [7:0] char_t;

	// One line of text, first character in the top byte
	typedef logic [8 * LINE_CHARS - 1:0] line_t;

	// Nibble position inside one part of the frame
	typedef logic [$clog2(2 * LINE_CHARS) - 1:0] step_t;

	// Character position inside a line
	typedef logic [$clog2(LINE_CHARS) - 1:0] char_idx_t;

	// Last nibble position of each part
	localparam step_t WAKE_LAST_STEP = step_t'(WAKE_NIBBLES - 1);
	localparam step_t CONFIG_LAST_STEP = step_t'(2 * CONFIG_BYTES - 1);
	localparam step_t ADDR_LAST_STEP = step_t'(1);
	localparam step_t TEXT_LAST_STEP = step_t'(2 * LINE_CHARS - 1);

	////////////////////
	// Bus codes
	////////////////////

	// Wake-up sequence is three 3h then 2h to enter 4-bit mode
	localparam nibble_t WAKE_NIBBLE = 4'h3;
	localparam nibble_t BUS4_NIBBLE = 4'h2;

	// 4-bit bus, two lines, 5x8 font
	localparam char_t CMD_FUNCTION_SET = 8'h28;
	// Increment, no shift
	localparam char_t CMD_ENTRY_MODE = 8'h06;
	// Display on, cursor off
	localparam char_t CMD_DISPLAY_ON = 8'h0C;
	localparam char_t CMD_CLEAR = 8'h01;
	localparam char_t CMD_LINE1_ADDR = 8'h80;
	localparam char_t CMD_LINE2_ADDR = 8'hC0;

endpackage

`default_nettype wire

// File: lcd_tick_gen.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_tick_gen (
	input logic clk,
	input logic arst_n,
	input lcd_timing_pkg::tick_cnt_t tick_cycles,
	output logic tick
);

	lcd_timing_pkg::tick_cnt_t cnt;
	logic at_end;

	// Also wraps if the period is lowered while counting
	assign at_end = (cnt >= tick_cycles - 1'b1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
			tick <= 1'b0;
		end else begin
			tick <= at_end;
			if (at_end) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: lcd_nibble_writer.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_nibble_writer (
	input logic clk,
	input logic arst_n,
	input logic tick,
	input logic nib_valid,
	input lcd_cmd_pkg::nibble_t nib_data,
	input logic nib_rs,
	output logic busy,
	output logic lcd_rs,
	output lcd_cmd_pkg::nibble_t lcd_db,
	output logic lcd_e
);

	// Each state names the phase that the next tick starts
	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_strobe_high,
		st_strobe_low
	} state_t;

	state_t state;
	lcd_cmd_pkg::nibble_t data_q;
	logic rs_q;

	assign busy = (state != st_idle);

	////////////////////
	// Accepted nibble
	////////////////////

	always_ff @(posedge clk) begin
		if (state == st_idle && nib_valid) begin
			data_q <= nib_data;
			rs_q <= nib_rs;
		end
	end

	////////////////////
	// Phase FSM
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			lcd_rs <= 1'b0;
			lcd_db <= '0;
			lcd_e <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (nib_valid) begin
						state <= st_setup;
					end
				end
				st_setup: begin
					// Bus settles with E low
					if (tick) begin
						lcd_rs <= rs_q;
						lcd_db <= data_q;
						state <= st_strobe_high;
					end
				end
				st_strobe_high: begin
					if (tick) begin
						lcd_e <= 1'b1;
						state <= st_strobe_low;
					end
				end
				st_strobe_low: begin
					// LCD latches here, bus held until the next setup
					if (tick) begin
						lcd_e <= 1'b0;
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: lcd_frame_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_frame_sequencer (
	input logic clk,
	input logic arst_n,
	input lcd_cmd_pkg::line_t line1,
	input lcd_cmd_pkg::line_t line2,
	input logic busy,
	output logic nib_valid,
	output lcd_cmd_pkg::nibble_t nib_data,
	output logic nib_rs
);

	typedef enum logic [2:0] {
		st_wake,
		st_config,
		st_text1,
		st_addr2,
		st_text2
	} state_t;

	state_t state;
	state_t state_nxt;
	lcd_cmd_pkg::step_t step;
	lcd_cmd_pkg::step_t step_nxt;
	lcd_cmd_pkg::line_t line1_q;
	lcd_cmd_pkg::line_t line2_q;
	lcd_cmd_pkg::char_t cur_byte;
	lcd_cmd_pkg::nibble_t sel_nib;
	logic sel_rs;
	logic last_step;
	logic issue;
	logic frame_start;

	function automatic lcd_cmd_pkg::char_t char_at(
		input lcd_cmd_pkg::line_t text,
		input lcd_cmd_pkg::char_idx_t idx
	);
		return text[(lcd_cmd_pkg::LINE_CHARS - 1 - idx) * 8 +: 8];
	endfunction

	// Init commands in the order they go out
	function automatic lcd_cmd_pkg::char_t config_byte(input logic [2:0] idx);
		case (idx)
			3'd0: return lcd_cmd_pkg::CMD_FUNCTION_SET;
			3'd1: return lcd_cmd_pkg::CMD_ENTRY_MODE;
			3'd2: return lcd_cmd_pkg::CMD_DISPLAY_ON;
			3'd3: return lcd_cmd_pkg::CMD_CLEAR;
			default: return lcd_cmd_pkg::CMD_LINE1_ADDR;
		endcase
	endfunction

	// One nibble in flight, the next waits for the writer to go idle
	assign issue = !busy && !nib_valid;
	assign frame_start = (state == st_wake) && (step == '0);

	////////////////////
	// Nibble select
	////////////////////

	always_comb begin
		cur_byte = lcd_cmd_pkg::CMD_LINE2_ADDR;
		sel_rs = 1'b0;
		last_step = 1'b0;
		case (state)
			st_wake: begin
				last_step = (step == lcd_cmd_pkg::WAKE_LAST_STEP);
			end
			st_config: begin
				cur_byte = config_byte(step[3:1]);
				last_step = (step == lcd_cmd_pkg::CONFIG_LAST_STEP);
			end
			st_text1: begin
				cur_byte = char_at(line1_q, lcd_cmd_pkg::char_idx_t'(step >> 1));
				sel_rs = 1'b1;
				last_step = (step == lcd_cmd_pkg::TEXT_LAST_STEP);
			end
			st_addr2: begin
				last_step = (step == lcd_cmd_pkg::ADDR_LAST_STEP);
			end
			st_text2: begin
				cur_byte = char_at(line2_q, lcd_cmd_pkg::char_idx_t'(step >> 1));
				sel_rs = 1'b1;
				last_step = (step == lcd_cmd_pkg::TEXT_LAST_STEP);
			end
			default: begin
				last_step = 1'b1;
			end
		endcase

		// High nibble on even steps
		if (state == st_wake) begin
			sel_nib = last_step ? lcd_cmd_pkg::BUS4_NIBBLE : lcd_cmd_pkg::WAKE_NIBBLE;
		end else begin
			sel_nib = step[0] ? cur_byte[3:0] : cur_byte[7:4];
		end
	end

	////////////////////
	// Next position
	////////////////////

	always_comb begin
		state_nxt = state;
		step_nxt = step + 1'b1;
		if (last_step) begin
			step_nxt = '0;
			case (state)
				st_wake: state_nxt = st_config;
				st_config: state_nxt = st_text1;
				st_text1: state_nxt = st_addr2;
				st_addr2: state_nxt = st_text2;
				default: state_nxt = st_wake;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_wake;
			step <= '0;
			nib_valid <= 1'b0;
			nib_data <= '0;
			nib_rs <= 1'b0;
		end else begin
			nib_valid <= issue;
			if (issue) begin
				nib_data <= sel_nib;
				nib_rs <= sel_rs;
				state <= state_nxt;
				step <= step_nxt;
			end
		end
	end

	// Text frozen for the whole frame
	always_ff @(posedge clk) begin
		if (issue && frame_start) begin
			line1_q <= line1;
			line2_q <= line2;
		end
	end

endmodule

`default_nettype wire

// File: lcd_text_driver.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_text_driver #(
	parameter lcd_timing_pkg::tick_cnt_t tick_cycles = lcd_timing_pkg::TICK_CYCLES
) (
	input logic clk,
	input logic arst_n,
	input lcd_cmd_pkg::line_t line1,
	input lcd_cmd_pkg::line_t line2,
	output logic lcd_rs,
	output logic lcd_rw,
	output logic lcd_e,
	output lcd_cmd_pkg::nibble_t lcd_db
);

	logic tick;
	logic nib_valid;
	lcd_cmd_pkg::nibble_t nib_data;
	logic nib_rs;
	logic busy;

	// Write only
	assign lcd_rw = 1'b0;

	////////////////////
	// Phase timing
	////////////////////

	lcd_tick_gen u_tick (
		.clk(clk),
		.arst_n(arst_n),
		.tick_cycles(tick_cycles),
		.tick(tick)
	);

	////////////////////
	// Frame content
	////////////////////

	lcd_frame_sequencer u_seq (
		.clk(clk),
		.arst_n(arst_n),
		.line1(line1),
		.line2(line2),
		.busy(busy),
		.nib_valid(nib_valid),
		.nib_data(nib_data),
		.nib_rs(nib_rs)
	);

	////////////////////
	// Bus cycles
	////////////////////

	lcd_nibble_writer u_writer (
		.clk(clk),
		.arst_n(arst_n),
		.tick(tick),
		.nib_valid(nib_valid),
		.nib_data(nib_data),
		.nib_rs(nib_rs),
		.busy(busy),
		.lcd_rs(lcd_rs),
		.lcd_db(lcd_db),
		.lcd_e(lcd_e)
	);

endmodule

`default_nettype wire

// File: tb_lcd_text_driver.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lcd_text_driver;

	localparam int ROWS = 3;
	localparam int FRAME_NIBBLES = 80;
	// Generous clock budget per nibble for the short tick
	localparam int NIBBLE_BUDGET = 40;

	logic clk;
	logic arst_n;
	lcd_cmd_pkg::line_t line1;
	lcd_cmd_pkg::line_t line2;
	logic lcd_rs;
	logic lcd_rw;
	logic lcd_e;
	lcd_cmd_pkg::nibble_t lcd_db;

	// Stimulus table with one row per test pair
	lcd_cmd_pkg::line_t tbl_line1 [ROWS];
	lcd_cmd_pkg::line_t tbl_line2 [ROWS];
	lcd_cmd_pkg::line_t tbl_alt [ROWS];

	// Captured and expected bus words as {rs, db}
	logic [4:0] cap_q [$];
	logic [4:0] exp_q [$];

	logic [31:0] lfsr;
	int errors;
	int tests_run;
	int tests_failed;
	bit timed_out;

	lcd_text_driver #(
		.tick_cycles(20'd4)
	) u_dut (
		.clk(clk),
		.arst_n(arst_n),
		.line1(line1),
		.line2(line2),
		.lcd_rs(lcd_rs),
		.lcd_rw(lcd_rw),
		.lcd_e(lcd_e),
		.lcd_db(lcd_db)
	);

	always #4 clk = ~clk;

	////////////////////
	// Bus monitor
	////////////////////

	// LCD latches on the falling edge of E
	always @(negedge lcd_e) begin
		if (arst_n === 1'b1) begin
			cap_q.push_back({lcd_rs, lcd_db});
		end
	end

	always @(posedge clk) begin
		if (lcd_rw !== 1'b0) begin
			errors++;
			$display("Fail at %0t ns: lcd_rw is %b instead of write", $time, lcd_rw);
		end
	end

	////////////////////
	// Helpers
	////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_line(output lcd_cmd_pkg::line_t text);
		lcd_cmd_pkg::char_t b;
		text = '0;
		for (int i = 0; i < lcd_cmd_pkg::LINE_CHARS; i++) begin
			b = '0;
			for (int k = 0; k < 8; k++) begin
				lfsr = lfsr_next(lfsr);
				b = {b[6:0], lfsr[0]};
			end
			text = {text[8 * lcd_cmd_pkg::LINE_CHARS - 9:0], b};
		end
	endtask

	task automatic push_byte(input lcd_cmd_pkg::char_t b, input logic rs);
		exp_q.push_back({rs, b[7:4]});
		exp_q.push_back({rs, b[3:0]});
	endtask

	task automatic build_expected(input lcd_cmd_pkg::line_t l1, input lcd_cmd_pkg::line_t l2);
		exp_q.delete();
		for (int i = 0; i < 3; i++) begin
			exp_q.push_back({1'b0, lcd_cmd_pkg::WAKE_NIBBLE});
		end
		exp_q.push_back({1'b0, lcd_cmd_pkg::BUS4_NIBBLE});
		push_byte(lcd_cmd_pkg::CMD_FUNCTION_SET, 1'b0);
		push_byte(lcd_cmd_pkg::CMD_ENTRY_MODE, 1'b0);
		push_byte(lcd_cmd_pkg::CMD_DISPLAY_ON, 1'b0);
		push_byte(lcd_cmd_pkg::CMD_CLEAR, 1'b0);
		push_byte(lcd_cmd_pkg::CMD_LINE1_ADDR, 1'b0);
		for (int i = 0; i < lcd_cmd_pkg::LINE_CHARS; i++) begin
			push_byte(l1[8 * (lcd_cmd_pkg::LINE_CHARS - 1 - i) +: 8], 1'b1);
		end
		push_byte(lcd_cmd_pkg::CMD_LINE2_ADDR, 1'b0);
		for (int i = 0; i < lcd_cmd_pkg::LINE_CHARS; i++) begin
			push_byte(l2[8 * (lcd_cmd_pkg::LINE_CHARS - 1 - i) +: 8], 1'b1);
		end
	endtask

	task automatic check_idle_bus(input string phase, inout int bad);
		if (lcd_e !== 1'b0 || lcd_rs !== 1'b0 || lcd_db !== 4'h0) begin
			bad++;
			$display("Fail at %0t ns: bus not idle %s, e=%b rs=%b db=%h",
				$time, phase, lcd_e, lcd_rs, lcd_db);
		end
	endtask

	task automatic wait_nibbles(input int target);
		int cycles;
		int limit;
		cycles = 0;
		limit = (target - cap_q.size()) * NIBBLE_BUDGET + 100;
		while (!timed_out && cap_q.size() < target) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > limit) begin
				timed_out = 1'b1;
				errors++;
				$display("Timeout: the LCD bus stopped after %0d of %0d nibbles",
					cap_q.size(), target);
			end
		end
	endtask

	task automatic apply_text(input lcd_cmd_pkg::line_t l1, input lcd_cmd_pkg::line_t l2);
		@(posedge clk);
		#1;
		line1 = l1;
		line2 = l2;
	endtask

	task automatic check_frame(input int r, input int frame, input lcd_cmd_pkg::line_t l1,
		input lcd_cmd_pkg::line_t l2, input string what);
		int bad;
		logic [4:0] got;
		bad = 0;
		build_expected(l1, l2);
		for (int k = 0; k < FRAME_NIBBLES; k++) begin
			got = cap_q[frame * FRAME_NIBBLES + k];
			if (got !== exp_q[k]) begin
				bad++;
				$display("Fail at %0t ns: row %0d frame %0d nibble %0d rs/db %b/%h, want %b/%h",
					$time, r, frame, k, got[4], got[3:0], exp_q[k][4], exp_q[k][3:0]);
			end
		end
		tests_run++;
		errors += bad;
		if (bad != 0) begin
			tests_failed++;
		end
		$display("Test row %0d frame %0d (%s): %0d mismatches", r, frame, what, bad);
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		int bad;
		int base;
		clk = 1'b0;
		arst_n = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		lfsr = 32'hd70a_b0c5;

		tbl_line1[0] = "Hello, LCD 16x2!";
		tbl_line2[0] = "Line two of text";
		tbl_alt[0] = "Updated text 123";
		for (int r = 1; r < ROWS; r++) begin
			random_line(tbl_line1[r]);
			random_line(tbl_line2[r]);
			random_line(tbl_alt[r]);
		end
		// First frame captures at reset release
		line1 = tbl_line1[0];
		line2 = tbl_line2[0];

		bad = 0;
		repeat (3) begin
			@(posedge clk);
			#1;
			check_idle_bus("during reset", bad);
		end
		arst_n = 1'b1;
		repeat (2) begin
			@(posedge clk);
			#1;
			check_idle_bus("after reset", bad);
		end
		tests_run++;
		errors += bad;
		if (bad != 0) begin
			tests_failed++;
		end
		$display("Test reset bus state: %0d mismatches", bad);

		// Each row spans two frames and the text changes halfway through both
		for (int r = 0; r < ROWS && !timed_out; r++) begin
			base = r * 2 * FRAME_NIBBLES;
			wait_nibbles(base + FRAME_NIBBLES / 2);
			if (!timed_out) begin
				apply_text(tbl_alt[r], tbl_alt[r]);
			end
			wait_nibbles(base + FRAME_NIBBLES + FRAME_NIBBLES / 2);
			if (!timed_out && r + 1 < ROWS) begin
				apply_text(tbl_line1[r + 1], tbl_line2[r + 1]);
			end
			wait_nibbles(base + 2 * FRAME_NIBBLES);
			if (!timed_out) begin
				check_frame(r, 2 * r, tbl_line1[r], tbl_line2[r], "original text");
				check_frame(r, 2 * r + 1, tbl_alt[r], tbl_alt[r], "replaced text");
			end
		end

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
lcd_timing_pkg.sv
lcd_cmd_pkg.sv
lcd_tick_gen.sv
lcd_nibble_writer.sv
lcd_frame_sequencer.sv
lcd_text_driver.sv
tb_lcd_text_driver.sv

// File: Bender.yml
package:
  name: lcd_text_driver

sources:
  - files:
      - lcd_timing_pkg.sv
      - lcd_cmd_pkg.sv
      - lcd_tick_gen.sv
      - lcd_nibble_writer.sv
      - lcd_frame_sequencer.sv
      - lcd_text_driver.sv
  - target: test
    files:
      - tb_lcd_text_driver.sv
